//--- pwm_macros.svh
// bus widths, channel count, register map, config bit positions and bridge command codes
`ifndef PWM_MACROS_SVH
`define PWM_MACROS_SVH

// bus and register widths
`define PWM_DATA_W          32
`define PWM_ADDR_W          8

// channels built by the top level
`define PWM_CHANNELS        2

// channel 0 starts at PWM_BASE, each channel takes PWM_REGS_PER_UNIT words
`define PWM_BASE            16
`define PWM_REGS_PER_UNIT   4

// register offsets inside one channel window
`define PWM_PERIOD          0
`define PWM_ON_TIME         1
`define PWM_CONFIG          2
`define PWM_STATUS          3

// config register fields
`define PWM_ENABLE_BIT      0
`define BRIDGE_ENABLE_BIT   1
`define BRIDGE_CMD_LSB      2
`define BRIDGE_CMD_W        3
`define BRIDGE_SWAP_BIT     5
`define BRIDGE_INVERT_LSB   6
`define BRIDGE_INVERT_W     2

// bridge commands, codes 4 to 7 act as coast
`define CMD_COAST           3'd0
`define CMD_FORWARD         3'd1
`define CMD_REVERSE         3'd2
`define CMD_BRAKE           3'd3

`endif

//--- pwm_pkg.sv
// pwm_pkg: word, address and cycle count types, bus request/response structs, FSM enums
`include "pwm_macros.svh"
`default_nettype none

package pwm_pkg;

    // one register or bus data word
    typedef logic [`PWM_DATA_W-1:0] bus_word_t;

    // register address on the internal bus
    typedef logic [`PWM_ADDR_W-1:0] reg_addr_t;

    // a time measured in clock cycles
    typedef logic [`PWM_DATA_W-1:0] cycle_count_t;

    // host to peripheral, 42 bits
    typedef struct packed {
        // request level of the four-phase handshake
        logic      req;
        // 1 write, 0 read
        logic      rw;
        reg_addr_t addr;
        bus_word_t wdata;
    } bus_req_t;

    // peripheral to host, 33 bits
    typedef struct packed {
        // acknowledge level
        logic      ack;
        bus_word_t rdata;
    } bus_resp_t;

    // peripheral side of the handshake
    typedef enum logic [1:0] {
        bus_idle,
        bus_respond,
        bus_release
    } bus_state_t;

    // pwm generator states
    typedef enum logic [1:0] {
        pwm_stopped,
        pwm_on_phase,
        pwm_off_phase
    } pwm_state_t;

endpackage

`default_nettype wire

//--- bus_slave_fsm.sv
// bus_slave_fsm: peripheral end of the four-phase bus handshake with one-cycle strobes
`default_nettype none

module bus_slave_fsm (
    input  logic clk,
    input  logic reset,
    input  logic req,
    input  logic rw,
    input  logic selected,
    output logic write_strobe,
    output logic read_strobe,
    output logic ack
);
    import pwm_pkg::*;

    bus_state_t state;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state        <= bus_idle;
            write_strobe <= 1'b0;
            read_strobe  <= 1'b0;
            ack          <= 1'b0;
        end else begin
            // strobes last a single cycle
            write_strobe <= 1'b0;
            read_strobe  <= 1'b0;
            case (state)
                bus_idle: begin
                    ack <= 1'b0;
                    // new transfer addressed to this channel
                    if (req && selected) begin
                        write_strobe <= rw;
                        read_strobe  <= !rw;
                        state        <= bus_respond;
                    end
                end
                bus_respond: begin
                    // ack rises together with the register update / read capture
                    ack <= 1'b1;
                    // host has seen ack and dropped req
                    if (ack && !req) begin
                        state <= bus_release;
                    end
                end
                bus_release: begin
                    // ack falls one edge after req was sampled low
                    ack   <= 1'b0;
                    state <= bus_idle;
                end
                default: begin
                    ack   <= 1'b0;
                    state <= bus_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- pwm_timer.sv
// pwm_timer: pwm FSM with period and on-time down-counters reloaded at each period start
`default_nettype none

module pwm_timer (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  enable,
    input  pwm_pkg::cycle_count_t period,
    input  pwm_pkg::cycle_count_t on_time,
    output logic                  pwm
);
    import pwm_pkg::*;

    pwm_state_t   state;
    cycle_count_t period_count;
    cycle_count_t on_count;

    // periods shorter than two cycles never start
    logic       period_valid;
    // phase entered at the start of every period
    pwm_state_t start_state;

    assign period_valid = (period > cycle_count_t'(1));
    assign start_state  = (on_time == '0) ? pwm_off_phase : pwm_on_phase;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state        <= pwm_stopped;
            period_count <= '0;
            on_count     <= '0;
        end else if (!enable) begin
            // disabling stops the output at the next edge
            state <= pwm_stopped;
        end else if (state == pwm_stopped || period_count == '0) begin
            // period start, reload both counters
            if (period_valid) begin
                state        <= start_state;
                period_count <= period - cycle_count_t'(1);
                // wraps when on_time is zero, unused in the off phase
                on_count     <= on_time - cycle_count_t'(1);
            end else begin
                state <= pwm_stopped;
            end
        end else begin
            period_count <= period_count - cycle_count_t'(1);
            // on-time runs out before the period ends
            if (state == pwm_on_phase) begin
                if (on_count == '0) begin
                    state <= pwm_off_phase;
                end else begin
                    on_count <= on_count - cycle_count_t'(1);
                end
            end
        end
    end

    // output is high only during the on phase
    assign pwm = (state == pwm_on_phase);

endmodule

`default_nettype wire

//--- h_bridge_drive.sv
// h_bridge_drive: combinational decode of pwm level and config fields into two bridge pins
`include "pwm_macros.svh"
`default_nettype none

module h_bridge_drive (
    input  logic       pwm,
    input  logic       bridge_enable,
    input  logic       swap,
    input  logic [2:0] command,
    input  logic [1:0] invert,
    output logic       h_bridge_1,
    output logic       h_bridge_2
);

    // pin pair straight from the command
    logic raw_1;
    logic raw_2;
    // after optional exchange of the pins
    logic swapped_1;
    logic swapped_2;

    always_comb begin
        case (command)
            `CMD_FORWARD: begin
                raw_1 = pwm;
                raw_2 = 1'b0;
            end
            `CMD_REVERSE: begin
                raw_1 = 1'b0;
                raw_2 = pwm;
            end
            `CMD_BRAKE: begin
                raw_1 = 1'b1;
                raw_2 = 1'b1;
            end
            // coast and the unused codes leave both pins low
            default: begin
                raw_1 = 1'b0;
                raw_2 = 1'b0;
            end
        endcase
    end

    assign swapped_1 = swap ? raw_2 : raw_1;
    assign swapped_2 = swap ? raw_1 : raw_2;

    // inversion follows the swap, a disabled bridge forces both pins low
    assign h_bridge_1 = bridge_enable & (swapped_1 ^ invert[0]);
    assign h_bridge_2 = bridge_enable & (swapped_2 ^ invert[1]);

endmodule

`default_nettype wire

//--- pwm_channel.sv
// pwm_channel: address decode, register file, status and read data for one pwm channel
`include "pwm_macros.svh"
`default_nettype none

module pwm_channel #(
    parameter int channel_index = 0
) (
    input  logic               clk,
    input  logic               reset,
    input  pwm_pkg::bus_req_t  bus_req,
    output pwm_pkg::bus_resp_t bus_resp,
    output logic               pwm_signal,
    output logic               h_bridge_1,
    output logic               h_bridge_2
);
    import pwm_pkg::*;

    // first and last address of this channel's window
    localparam reg_addr_t first_addr =
        reg_addr_t'(`PWM_BASE + channel_index * `PWM_REGS_PER_UNIT);
    localparam reg_addr_t last_addr =
        reg_addr_t'(first_addr + `PWM_REGS_PER_UNIT - 1);

    // register file
    cycle_count_t period_reg;
    cycle_count_t on_time_reg;
    bus_word_t    config_reg;
    bus_word_t    status_word;
    // read data held while ack is high
    bus_word_t    rdata_reg;

    reg_addr_t reg_offset;
    logic      selected;
    logic      write_strobe;
    logic      read_strobe;
    logic      ack;
    logic      pwm;

    // config fields for the bridge decoder
    logic                       bridge_enable;
    logic                       bridge_swap;
    logic [`BRIDGE_CMD_W-1:0]    bridge_cmd;
    logic [`BRIDGE_INVERT_W-1:0] bridge_invert;

    assign selected   = (bus_req.addr >= first_addr) && (bus_req.addr <= last_addr);
    assign reg_offset = bus_req.addr - first_addr;

    bus_slave_fsm u_bus_fsm (
        .clk          (clk),
        .reset        (reset),
        .req          (bus_req.req),
        .rw           (bus_req.rw),
        .selected     (selected),
        .write_strobe (write_strobe),
        .read_strobe  (read_strobe),
        .ack          (ack)
    );

    // register writes, a new period or on-time stops the timer
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            period_reg  <= '0;
            on_time_reg <= '0;
            config_reg  <= '0;
        end else if (write_strobe) begin
            case (reg_offset)
                `PWM_PERIOD: begin
                    period_reg                  <= bus_req.wdata;
                    config_reg[`PWM_ENABLE_BIT] <= 1'b0;
                end
                `PWM_ON_TIME: begin
                    on_time_reg                 <= bus_req.wdata;
                    config_reg[`PWM_ENABLE_BIT] <= 1'b0;
                end
                `PWM_CONFIG: config_reg <= bus_req.wdata;
                // status is read only
                default: ;
            endcase
        end
    end

    // pwm level on top, config low half below
    assign status_word = {pwm, 15'b0, config_reg[15:0]};

    // capture the addressed word on the read strobe
    always_ff @(posedge clk) begin
        if (read_strobe) begin
            case (reg_offset)
                `PWM_PERIOD:  rdata_reg <= period_reg;
                `PWM_ON_TIME: rdata_reg <= on_time_reg;
                `PWM_CONFIG:  rdata_reg <= config_reg;
                `PWM_STATUS:  rdata_reg <= status_word;
                default:      rdata_reg <= '0;
            endcase
        end
    end

    // quiet bus unless this channel acknowledges
    assign bus_resp.ack   = ack;
    assign bus_resp.rdata = ack ? rdata_reg : '0;

    pwm_timer u_timer (
        .clk     (clk),
        .reset   (reset),
        .enable  (config_reg[`PWM_ENABLE_BIT]),
        .period  (period_reg),
        .on_time (on_time_reg),
        .pwm     (pwm)
    );

    assign bridge_enable = config_reg[`BRIDGE_ENABLE_BIT];
    assign bridge_swap   = config_reg[`BRIDGE_SWAP_BIT];
    assign bridge_cmd    = config_reg[`BRIDGE_CMD_LSB +: `BRIDGE_CMD_W];
    assign bridge_invert = config_reg[`BRIDGE_INVERT_LSB +: `BRIDGE_INVERT_W];

    h_bridge_drive u_bridge (
        .pwm           (pwm),
        .bridge_enable (bridge_enable),
        .swap          (bridge_swap),
        .command       (bridge_cmd),
        .invert        (bridge_invert),
        .h_bridge_1    (h_bridge_1),
        .h_bridge_2    (h_bridge_2)
    );

    assign pwm_signal = pwm;

endmodule

`default_nettype wire

//--- pwm_subsystem.sv
// pwm_subsystem: top level with the generated pwm channels and the merged bus response
`include "pwm_macros.svh"
`default_nettype none

module pwm_subsystem (
    input  logic                     clk,
    input  logic                     reset,
    input  pwm_pkg::bus_req_t        bus_req,
    output pwm_pkg::bus_resp_t       bus_resp,
    output logic [`PWM_CHANNELS-1:0] pwm_signal,
    output logic [`PWM_CHANNELS-1:0] h_bridge_1,
    output logic [`PWM_CHANNELS-1:0] h_bridge_2
);
    import pwm_pkg::*;

    // one response per channel, idle channels drive all zeros
    bus_resp_t channel_resp [`PWM_CHANNELS];

    // every channel sees the full request and decodes its own window
    for (genvar i = 0; i < `PWM_CHANNELS; i++) begin : g_channel
        pwm_channel #(
            .channel_index (i)
        ) u_channel (
            .clk        (clk),
            .reset      (reset),
            .bus_req    (bus_req),
            .bus_resp   (channel_resp[i]),
            .pwm_signal (pwm_signal[i]),
            .h_bridge_1 (h_bridge_1[i]),
            .h_bridge_2 (h_bridge_2[i])
        );
    end

    // windows do not overlap, so OR of the responses is the selected one
    always_comb begin
        bus_resp = '0;
        for (int i = 0; i < `PWM_CHANNELS; i++) begin
            bus_resp = bus_resp | channel_resp[i];
        end
    end

endmodule

`default_nettype wire

//--- pwm_subsystem_asserts.sv
// pwm_subsystem_asserts: concurrent checks on the bus handshake, channel acks and bridge pins
`include "pwm_macros.svh"
`default_nettype none

module pwm_subsystem_asserts (
    input logic                     clk,
    input logic                     reset,
    input pwm_pkg::bus_req_t        bus_req,
    input pwm_pkg::bus_resp_t       bus_resp,
    input logic [`PWM_CHANNELS-1:0] channel_ack,
    input logic [`PWM_CHANNELS-1:0] bridge_enable,
    input logic [`PWM_CHANNELS-1:0] h_bridge_1,
    input logic [`PWM_CHANNELS-1:0] h_bridge_2
);
    timeunit 1ns;
    timeprecision 100ps;

    // ack only rises in answer to a request seen on the previous edge
    ack_follows_req: assert property (
        @(posedge clk) disable iff (!reset) $rose(bus_resp.ack) |-> $past(bus_req.req))
        else $error("ack rose without a pending request");

    // at most one channel answers at a time
    single_channel_ack: assert property (
        @(posedge clk) disable iff (!reset) $onehot0(channel_ack))
        else $error("more than one channel acknowledged together");

    // a disabled bridge holds both pins low, inversion included
    pins_low_when_disabled: assert property (
        @(posedge clk) disable iff (!reset)
        ((h_bridge_1 | h_bridge_2) & ~bridge_enable) == '0)
        else $error("bridge pin high while the bridge is disabled");

endmodule

// one copy on the top level, sees the acks and bridge enables of both channels
bind pwm_subsystem pwm_subsystem_asserts u_asserts (
    .clk           (clk),
    .reset         (reset),
    .bus_req       (bus_req),
    .bus_resp      (bus_resp),
    .channel_ack   ({channel_resp[1].ack, channel_resp[0].ack}),
    .bridge_enable ({g_channel[1].u_channel.bridge_enable,
                     g_channel[0].u_channel.bridge_enable}),
    .h_bridge_1    (h_bridge_1),
    .h_bridge_2    (h_bridge_2)
);

`default_nettype wire

//--- pwm_subsystem_tb.sv
// pwm_subsystem_tb: clock, reset, bus tasks, directed tests, watchdog and summary
`include "pwm_macros.svh"
`default_nettype none

module pwm_subsystem_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import pwm_pkg::*;

    localparam int clk_period  = 4;
    // cycles the host waits for ack before giving up
    localparam int ack_limit   = 16;
    localparam int trace_len   = 128;
    // upper bound on one complete four-phase transfer
    localparam int xfer_cycles = 8;
    // rough length of all tests, the watchdog allows twice this
    localparam int budget_cycles =
        100 * xfer_cycles + 11 * trace_len + 256 * (xfer_cycles + 2);

    logic                     clk;
    logic                     reset;
    bus_req_t                 bus_req;
    bus_resp_t                bus_resp;
    logic [`PWM_CHANNELS-1:0] pwm_signal;
    logic [`PWM_CHANNELS-1:0] h_bridge_1;
    logic [`PWM_CHANNELS-1:0] h_bridge_2;

    int          error_count;
    int          tests_run;
    int          tests_with_errors;
    logic [31:0] lcg_state;
    // pwm level of every channel, one entry per cycle
    logic [`PWM_CHANNELS-1:0] trace [trace_len];

    pwm_subsystem dut (
        .clk        (clk),
        .reset      (reset),
        .bus_req    (bus_req),
        .bus_resp   (bus_resp),
        .pwm_signal (pwm_signal),
        .h_bridge_1 (h_bridge_1),
        .h_bridge_2 (h_bridge_2)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(2 * budget_cycles * clk_period);
        $display("watchdog timeout: run exceeded %0d clock cycles", 2 * budget_cycles);
        $display("tests failed");
        $finish;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic reg_addr_t reg_address(input int ch, input int offset);
        return reg_addr_t'(`PWM_BASE + ch * `PWM_REGS_PER_UNIT + offset);
    endfunction

    // pin pair {h_bridge_2, h_bridge_1} from the command table, swap, invert, enable
    function automatic logic [1:0] expected_pins(input logic [2:0] cmd, input logic swap,
                                                 input logic [1:0] inv, input logic en,
                                                 input logic level);
        logic p1;
        logic p2;
        logic t;
        p1 = 1'b0;
        p2 = 1'b0;
        if (cmd == `CMD_FORWARD) p1 = level;
        if (cmd == `CMD_REVERSE) p2 = level;
        if (cmd == `CMD_BRAKE) begin
            p1 = 1'b1;
            p2 = 1'b1;
        end
        if (swap) begin
            t  = p1;
            p1 = p2;
            p2 = t;
        end
        p1 = p1 ^ inv[0];
        p2 = p2 ^ inv[1];
        return en ? {p2, p1} : 2'b00;
    endfunction

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        assert (got === exp) else begin
            error_count++;
            $display("CHECK FAILED at %0t: %s, got 0x%h, expected 0x%h",
                     $time, what, got, exp);
        end
    endtask

    // one four-phase transfer, inputs change on the falling edge
    task automatic bus_transfer(input logic rw, input reg_addr_t addr, input bus_word_t wdata,
                                output bus_word_t rdata);
        int waited;
        rdata = '0;
        @(negedge clk);
        bus_req.addr  = addr;
        bus_req.rw    = rw;
        bus_req.wdata = wdata;
        bus_req.req   = 1'b1;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!bus_resp.ack && waited < ack_limit);
        if (!bus_resp.ack) begin
            error_count++;
            $display("bus error: no ack from address 0x%h within %0d cycles", addr, ack_limit);
        end else begin
            rdata = bus_resp.rdata;
        end
        bus_req.req = 1'b0;
        waited = 0;
        while (bus_resp.ack && waited < ack_limit) begin
            @(negedge clk);
            waited++;
        end
        if (bus_resp.ack) begin
            error_count++;
            $display("bus error: ack from address 0x%h stayed high after req dropped", addr);
        end
    endtask

    task automatic bus_write(input int ch, input int offset, input bus_word_t data);
        bus_word_t unused;
        bus_transfer(1'b1, reg_address(ch, offset), data, unused);
    endtask

    task automatic bus_read(input int ch, input int offset, output bus_word_t data);
        bus_transfer(1'b0, reg_address(ch, offset), '0, data);
    endtask

    task automatic read_check(input int ch, input int offset, input bus_word_t exp,
                              input string what);
        bus_word_t data;
        bus_read(ch, offset, data);
        check_equal(data, exp, $sformatf("ch%0d reg %0d %s", ch, offset, what));
    endtask

    // request to an address no channel owns, ack must stay low
    task automatic probe_unmapped(input reg_addr_t addr);
        logic acked;
        acked = 1'b0;
        @(negedge clk);
        bus_req.addr = addr;
        bus_req.rw   = 1'b0;
        bus_req.req  = 1'b1;
        repeat (8) begin
            @(negedge clk);
            if (bus_resp.ack) acked = 1'b1;
        end
        bus_req.req = 1'b0;
        check_equal(acked, 0, $sformatf("ack from unmapped address 0x%h", addr));
        repeat (4) @(negedge clk);
    endtask

    task automatic stop_channels();
        for (int ch = 0; ch < `PWM_CHANNELS; ch++) bus_write(ch, `PWM_CONFIG, '0);
    endtask

    task automatic count_high(input int ch, input int cycles, output int highs);
        highs = 0;
        repeat (cycles) begin
            @(negedge clk);
            if (pwm_signal[ch]) highs++;
        end
    endtask

    task automatic capture_trace();
        for (int i = 0; i < trace_len; i++) begin
            @(negedge clk);
            trace[i] = pwm_signal;
        end
    endtask

    // record pwm while the masked channels get enabled one after another
    task automatic start_and_trace(input logic [`PWM_CHANNELS-1:0] mask);
        fork
            capture_trace();
            begin
                for (int ch = 0; ch < `PWM_CHANNELS; ch++) begin
                    if (mask[ch]) bus_write(ch, `PWM_CONFIG, 32'h1);
                end
            end
        join
    endtask

    // from the first high cycle on, pwm is high for min(on, period) of every period
    task automatic check_waveform(input int ch, input int period, input int on_time);
        int   first_high;
        int   mismatches;
        int   high_len;
        int   highs;
        logic expected;
        first_high = -1;
        mismatches = 0;
        highs = 0;
        high_len = (on_time < period) ? on_time : period;
        for (int i = 0; i < trace_len; i++) begin
            if (trace[i][ch]) highs++;
            if (trace[i][ch] && first_high < 0) first_high = i;
        end
        if (period < 2 || on_time == 0) begin
            check_equal(highs, 0, $sformatf("ch%0d high cycles, period %0d on %0d",
                                            ch, period, on_time));
        end else begin
            check_equal(first_high >= 0 && first_high < 24, 1,
                        $sformatf("ch%0d pwm start after enable", ch));
            if (first_high >= 0) begin
                for (int i = first_high; i < trace_len; i++) begin
                    expected = ((i - first_high) % period) < high_len;
                    if (trace[i][ch] !== expected) mismatches++;
                end
            end
            check_equal(mismatches, 0, $sformatf("ch%0d waveform cycles, period %0d on %0d",
                                                 ch, period, on_time));
        end
    endtask

    task automatic finish_test(input string name, input int start_errors);
        tests_run++;
        if (error_count == start_errors) begin
            $display("%s: ok", name);
        end else begin
            tests_with_errors++;
            $display("%s: %0d errors", name, error_count - start_errors);
        end
    endtask

    task automatic test_reset_state();
        int start_errors;
        start_errors = error_count;
        check_equal(pwm_signal, 0, "pwm after reset");
        check_equal(h_bridge_1, 0, "h_bridge_1 after reset");
        check_equal(h_bridge_2, 0, "h_bridge_2 after reset");
        for (int ch = 0; ch < `PWM_CHANNELS; ch++) begin
            for (int off = 0; off < `PWM_REGS_PER_UNIT; off++) read_check(ch, off, '0, "reset");
        end
        finish_test("reset state", start_errors);
    endtask

    task automatic test_register_access();
        int        start_errors;
        bus_word_t values [3];
        bus_word_t cfg;
        start_errors = error_count;
        for (int ch = 0; ch < `PWM_CHANNELS; ch++) begin
            // config last, a period or on-time write would clear its enable bit
            for (int off = 0; off < 3; off++) begin
                values[off] = next_random();
                bus_write(ch, off, values[off]);
            end
            for (int off = 0; off < 3; off++) read_check(ch, off, values[off], "readback");
            // stopped timer, status bit 31 low
            cfg = values[2] & ~32'h1;
            bus_write(ch, `PWM_CONFIG, cfg);
            read_check(ch, `PWM_STATUS, {16'b0, cfg[15:0]}, "status stopped");
            // on-time past the period keeps pwm high
            bus_write(ch, `PWM_PERIOD, 32'd2);
            bus_write(ch, `PWM_ON_TIME, 32'd5);
            bus_write(ch, `PWM_CONFIG, cfg | 32'h1);
            repeat (3) @(negedge clk);
            read_check(ch, `PWM_STATUS, {1'b1, 15'b0, cfg[15:0] | 16'h1}, "status running");
        end
        stop_channels();
        probe_unmapped(reg_address(`PWM_CHANNELS, 0));
        probe_unmapped(reg_addr_t'(`PWM_BASE - 1));
        finish_test("register access", start_errors);
    endtask

    task automatic test_pwm_waveform();
        int start_errors;
        int periods [9];
        int on_times [9];
        start_errors = error_count;
        for (int i = 0; i < 6; i++) begin
            periods[i]  = 2 + int'(next_random() % 39);
            on_times[i] = int'(next_random() % (periods[i] + 3));
        end
        // on-time zero and periods below two never raise pwm
        periods[6] = 10;
        on_times[6] = 0;
        periods[7] = 1;
        on_times[7] = 5;
        periods[8] = 0;
        on_times[8] = 3;
        for (int i = 0; i < 9; i++) begin
            bus_write(0, `PWM_PERIOD, periods[i]);
            bus_write(0, `PWM_ON_TIME, on_times[i]);
            start_and_trace(1);
            check_waveform(0, periods[i], on_times[i]);
            // channel 1 is never enabled here
            check_waveform(1, 0, 0);
        end
        stop_channels();
        finish_test("pwm waveform", start_errors);
    endtask

    task automatic test_enable_clearing();
        int        start_errors;
        int        highs;
        bus_word_t cfg;
        start_errors = error_count;
        bus_write(0, `PWM_PERIOD, 32'd6);
        bus_write(0, `PWM_ON_TIME, 32'd3);
        bus_write(0, `PWM_CONFIG, 32'h1);
        count_high(0, 12, highs);
        check_equal(highs > 0, 1, "pwm running before period write");
        bus_write(0, `PWM_PERIOD, 32'd8);
        bus_read(0, `PWM_CONFIG, cfg);
        check_equal(cfg[`PWM_ENABLE_BIT], 0, "enable after period write");
        count_high(0, 20, highs);
        check_equal(highs, 0, "pwm high cycles after period write");
        bus_write(0, `PWM_CONFIG, 32'h1);
        count_high(0, 12, highs);
        check_equal(highs > 0, 1, "pwm running before on-time write");
        bus_write(0, `PWM_ON_TIME, 32'd4);
        bus_read(0, `PWM_CONFIG, cfg);
        check_equal(cfg[`PWM_ENABLE_BIT], 0, "enable after on-time write");
        count_high(0, 20, highs);
        check_equal(highs, 0, "pwm high cycles after on-time write");
        stop_channels();
        finish_test("enable clearing", start_errors);
    endtask

    task automatic test_h_bridge();
        int         start_errors;
        logic [7:0] cfg;
        logic [1:0] pins;
        start_errors = error_count;
        // with on-time past the period, the enable bit alone sets the pwm level
        bus_write(0, `PWM_PERIOD, 32'd2);
        bus_write(0, `PWM_ON_TIME, 32'd5);
        for (int i = 0; i < 256; i++) begin
            // bit 0 enable, 1 bridge enable, 4:2 command, 5 swap, 7:6 invert
            cfg = i[7:0];
            bus_write(0, `PWM_CONFIG, {24'b0, cfg});
            repeat (2) @(negedge clk);
            pins = expected_pins(cfg[4:2], cfg[5], cfg[7:6], cfg[1], cfg[0]);
            check_equal(pwm_signal[0], cfg[0], $sformatf("pwm level for config 0x%h", cfg));
            check_equal({h_bridge_2[0], h_bridge_1[0]}, pins,
                        $sformatf("bridge pins for config 0x%h", cfg));
            check_equal({h_bridge_2[1], h_bridge_1[1]}, 0, "idle channel 1 pins");
        end
        stop_channels();
        finish_test("h-bridge decode", start_errors);
    endtask

    task automatic test_channel_independence();
        int start_errors;
        int periods [`PWM_CHANNELS];
        int on_times [`PWM_CHANNELS];
        start_errors = error_count;
        for (int round = 0; round < 2; round++) begin
            for (int ch = 0; ch < `PWM_CHANNELS; ch++) begin
                if (round == 0) begin
                    periods[ch]  = 7 + 5 * ch;
                    on_times[ch] = 3 + 6 * ch;
                end else begin
                    periods[ch]  = 2 + int'(next_random() % 39);
                    on_times[ch] = 1 + int'(next_random() % (periods[ch] + 2));
                end
                bus_write(ch, `PWM_PERIOD, periods[ch]);
                bus_write(ch, `PWM_ON_TIME, on_times[ch]);
            end
            start_and_trace('1);
            for (int ch = 0; ch < `PWM_CHANNELS; ch++) begin
                check_waveform(ch, periods[ch], on_times[ch]);
            end
            stop_channels();
        end
        finish_test("channel independence", start_errors);
    endtask

    initial begin
        bus_req           = '0;
        reset             = 1'b0;
        error_count       = 0;
        tests_run         = 0;
        tests_with_errors = 0;
        lcg_state         = 32'hb241;
        repeat (5) @(negedge clk);
        reset = 1'b1;
        test_reset_state();
        test_register_access();
        test_pwm_waveform();
        test_enable_clearing();
        test_h_bridge();
        test_channel_independence();
        $display("tests run %0d, tests with errors %0d, check errors %0d",
                 tests_run, tests_with_errors, error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+.
pwm_pkg.sv
bus_slave_fsm.sv
pwm_timer.sv
h_bridge_drive.sv
pwm_channel.sv
pwm_subsystem.sv
pwm_subsystem_asserts.sv
pwm_subsystem_tb.sv
